// File: design/rvIsaPkg.sv
// RV32 ISA definitions: data words, register ids, function fields and ALU opcodes
package rvIsaPkg;

   typedef logic [31:0] wordT;    // Architectural data word
   typedef logic [4:0]  regIdT;   // Register number x0..x31
   typedef logic [2:0]  funct3T;  // Instruction funct3 field
   typedef logic [6:0]  opcodeT;  // Major opcode, instr[6:0]
   typedef logic [6:0]  funct7T;  // instr[31:25]

   // Major opcodes of the two integer ALU classes
   localparam opcodeT opcodeOp    = 7'b011_0011;  // Register-register
   localparam opcodeT opcodeOpImm = 7'b001_0011;  // Register-immediate

   // funct7 that tags the M extension inside OP
   localparam funct7T funct7MulDiv = 7'b000_0001;

   // Base ALU funct3 codes
   localparam funct3T f3AddSub = 3'd0;
   localparam funct3T f3Sll    = 3'd1;
   localparam funct3T f3Slt    = 3'd2;
   localparam funct3T f3Sltu   = 3'd3;
   localparam funct3T f3Xor    = 3'd4;
   localparam funct3T f3Sr     = 3'd5;  // SRL or SRA, split by bit 30
   localparam funct3T f3Or     = 3'd6;

   // Multiply funct3 codes; MULHU is whatever high form remains
   localparam funct3T f3Mul    = 3'd0;
   localparam funct3T f3Mulh   = 3'd1;
   localparam funct3T f3Mulhsu = 3'd2;

endpackage

// File: design/execPkg.sv
// Execute-path types: one decoded ALU operation and one finished result
package execPkg;

   import rvIsaPkg::*;

   // Everything the execute unit needs about one instruction
   typedef struct packed {
      logic   isMulDiv;  // M extension
      regIdT  rd;        // Destination register
      funct3T funct3;    // Operation select
      logic   alt;       // SUB or SRA/SRAI
      logic   isDivide;  // DIV, DIVU, REM, REMU
      wordT   in1;       // rs1 value
      wordT   in2;       // rs2 value or sign-extended I immediate
   } aluOpT;

   // Result handed back to the issuer
   typedef struct packed {
      regIdT rd;
      wordT  value;
   } aluResultT;

endpackage

// File: design/opDecoder.sv
// Operand decoder: turns an issued OP or OP-IMM instruction into a registered aluOpT
`timescale 1ns/1ps

module opDecoder import rvIsaPkg::*, execPkg::*; (
   input  logic  clk,
   input  logic  reset,
   input  logic  issueValid,
   input  wordT  issueInstr,
   input  wordT  issueRs1,
   input  wordT  issueRs2,
   output logic  decValid,
   output aluOpT decOp
);

   logic   isOp;
   logic   isOpImm;
   funct3T funct3;
   wordT   immI;
   logic   altAllowed;
   aluOpT  nextOp;

   assign isOp    = issueInstr[6:0] == opcodeOp;
   assign isOpImm = issueInstr[6:0] == opcodeOpImm;
   assign funct3  = issueInstr[14:12];

   // I-type immediate, sign taken from bit 31
   assign immI = {{20{issueInstr[31]}}, issueInstr[31:20]};

   // Bit 30 means SUB or SRA for OP, but only SRAI for OP-IMM
   // (ADDI reuses bit 30 as an immediate bit)
   assign altAllowed = isOp ? (funct3 == f3AddSub || funct3 == f3Sr)
                            : (funct3 == f3Sr);

   always_comb begin
      nextOp.isMulDiv = isOp & (issueInstr[31:25] == funct7MulDiv);
      nextOp.rd       = issueInstr[11:7];
      nextOp.funct3   = funct3;
      nextOp.alt      = issueInstr[30] & altAllowed;
      nextOp.isDivide = nextOp.isMulDiv & funct3[2];  // funct3 4..7 of M ext
      nextOp.in1      = issueRs1;
      nextOp.in2      = isOp ? issueRs2 : immI;
   end

   // Valid strobe, only for the two ALU opcode classes
   always_ff @(posedge clk) begin
      if (!reset) begin
         decValid <= 1'b0;
      end else begin
         decValid <= issueValid & (isOp | isOpImm);
      end
   end

   // Payload register
   always_ff @(posedge clk) begin
      if (issueValid) begin
         decOp <= nextOp;
      end
   end

endmodule

// File: design/opQueue.sv
// Operation queue: circular FIFO of decoded operations between decoder and execute unit
`timescale 1ns/1ps

module opQueue import execPkg::*; #(
   parameter int queueDepth = 4
) (
   input  logic  clk,
   input  logic  reset,
   input  logic  push,
   input  aluOpT pushOp,
   input  logic  pop,
   output aluOpT popOp,
   output logic  notEmpty
);

   // One slot more than queueDepth, taking the entry that drains from
   // the decoder register while a division holds the unit
   localparam int slots = queueDepth + 1;
   localparam int ptrW  = $clog2(slots);
   localparam int cntW  = $clog2(slots + 1);

   aluOpT           mem [slots];
   logic [ptrW-1:0] wrPtr;
   logic [ptrW-1:0] rdPtr;
   logic [cntW-1:0] count;
   logic            full;
   logic            doPush;
   logic            doPop;

   // Pointer advance with wrap at the last slot
   function automatic logic [ptrW-1:0] bump(input logic [ptrW-1:0] p);
      return (p == ptrW'(slots - 1)) ? '0 : p + 1'b1;
   endfunction

   assign notEmpty = count != '0;
   assign full     = count == cntW'(slots);
   assign doPop    = pop & notEmpty;
   assign doPush   = push & (~full | doPop);  // Lost when full with no pop
   assign popOp    = mem[rdPtr];               // Head, valid while notEmpty

   always_ff @(posedge clk) begin
      if (!reset) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (doPush) wrPtr <= bump(wrPtr);
         if (doPop)  rdPtr <= bump(rdPtr);
         count <= count + cntW'(doPush) - cntW'(doPop);
      end
   end

   always_ff @(posedge clk) begin
      if (doPush) begin
         mem[wrPtr] <= pushOp;
      end
   end

endmodule

// File: design/intAlu.sv
// Integer ALU: base RV32I operations plus MUL/MULH/MULHSU/MULHU, all combinational
`timescale 1ns/1ps

module intAlu import rvIsaPkg::*, execPkg::*; (
   input  aluOpT op,
   output wordT  value
);

   // Bit reversal, lets one right shifter do left shifts too
   function automatic wordT flip(input wordT x);
      wordT r;
      for (int i = 0; i < 32; i++) begin
         r[i] = x[31-i];
      end
      return r;
   endfunction

   wordT               sum;
   logic [32:0]        diff;
   logic               lt;
   logic               ltu;
   wordT               shIn;
   logic [32:0]        shOut;
   wordT               baseValue;
   logic               sign1;
   logic               sign2;
   logic signed [32:0] mulA;
   logic signed [32:0] mulB;
   logic signed [65:0] product;

   assign sum  = op.in1 + op.in2;
   assign diff = {1'b0, op.in1} - {1'b0, op.in2};  // Borrow lands in bit 32
   assign ltu  = diff[32];
   assign lt   = (op.in1[31] ^ op.in2[31]) ? op.in1[31] : diff[32];

   // Arithmetic fill only for SRA/SRAI
   assign shIn  = (op.funct3 == f3Sll) ? flip(op.in1) : op.in1;
   assign shOut = $signed({op.alt & op.in1[31], shIn}) >>> op.in2[4:0];

   always_comb begin
      case (op.funct3)
         f3AddSub: baseValue = op.alt ? diff[31:0] : sum;
         f3Sll:    baseValue = flip(shOut[31:0]);
         f3Slt:    baseValue = {31'b0, lt};
         f3Sltu:   baseValue = {31'b0, ltu};
         f3Xor:    baseValue = op.in1 ^ op.in2;
         f3Sr:     baseValue = shOut[31:0];
         f3Or:     baseValue = op.in1 | op.in2;
         default:  baseValue = op.in1 & op.in2;  // AND
      endcase
   end

   // 33x33 signed product; the extra bit carries the operand sign or zero
   // MULH signs both, MULHSU only rs1, MULHU neither
   assign sign1   = op.in1[31] & (op.funct3 == f3Mulh || op.funct3 == f3Mulhsu);
   assign sign2   = op.in2[31] & (op.funct3 == f3Mulh);
   assign mulA    = {sign1, op.in1};
   assign mulB    = {sign2, op.in2};
   assign product = mulA * mulB;

   // Divide codes also land on the high half here, the unit ignores them
   assign value = !op.isMulDiv          ? baseValue      :
                  (op.funct3 == f3Mul) ? product[31:0]  :
                                          product[63:32];

endmodule

// File: design/serialDivider.sv
// Serial divider: restoring compare-subtract over 32 steps for DIV, DIVU, REM, REMU
`timescale 1ns/1ps

module serialDivider import rvIsaPkg::*, execPkg::*; (
   input  logic  clk,
   input  logic  reset,
   input  logic  start,
   input  aluOpT op,
   output logic  done,
   output wordT  value
);

   logic        running;
   logic [4:0]  stepCnt;
   wordT        dividend;   // Running remainder
   logic [62:0] divisor;    // Divisor aligned to the current quotient bit
   wordT        quotient;
   wordT        quotMask;   // One-hot, bit being decided this step
   logic        wantRem;
   logic        negate;
   logic        isSigned;
   wordT        absIn1;
   wordT        absIn2;
   logic        stepDo;
   wordT        dividendNext;
   wordT        quotientNext;
   wordT        rawValue;

   assign isSigned = ~op.funct3[0];  // DIV and REM
   assign absIn1   = (isSigned & op.in1[31]) ? -op.in1 : op.in1;
   assign absIn2   = (isSigned & op.in2[31]) ? -op.in2 : op.in2;

   // One restoring step
   assign stepDo       = divisor <= {31'b0, dividend};
   assign dividendNext = stepDo ? dividend - divisor[31:0] : dividend;
   assign quotientNext = stepDo ? quotient | quotMask : quotient;

   // Step counter, done strobes after the 32nd step
   always_ff @(posedge clk) begin
      if (!reset) begin
         running <= 1'b0;
         stepCnt <= '0;
         done    <= 1'b0;
      end else begin
         done <= 1'b0;
         if (start) begin
            running <= 1'b1;
            stepCnt <= '0;
         end else if (running) begin
            stepCnt <= stepCnt + 1'b1;
            if (stepCnt == 5'd31) begin
               running <= 1'b0;
               done    <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         dividend <= absIn1;
         divisor  <= {absIn2, 31'b0};
         quotient <= '0;
         quotMask <= 32'h8000_0000;
         wantRem  <= op.funct3[1];
         // Remainder follows the dividend sign; quotient is negative on
         // differing signs, except divide by zero keeps all ones
         negate   <= op.funct3[1] ? isSigned & op.in1[31]
                                  : isSigned & (op.in1[31] ^ op.in2[31]) & (|op.in2);
      end else if (running) begin
         dividend <= dividendNext;
         divisor  <= divisor >> 1;
         quotient <= quotientNext;
         quotMask <= quotMask >> 1;
      end
   end

   // Stable from done until the next start
   assign rawValue = wantRem ? dividend : quotient;
   assign value    = negate ? -rawValue : rawValue;

endmodule

// File: design/execUnit.sv
// Execute unit: pops the queue, runs the ALU or the divider, returns results in order
`timescale 1ns/1ps

module execUnit import rvIsaPkg::*, execPkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  logic      notEmpty,
   input  aluOpT     headOp,
   output logic      pop,
   output logic      resultValid,
   output aluResultT result
);

   typedef enum logic {
      idle,
      dividing
   } stateT;

   stateT state;
   wordT  aluValue;
   wordT  divValue;
   logic  divStart;
   logic  divDone;
   regIdT divRd;  // rd of the division in flight

   intAlu iAlu (
      .op    (headOp),
      .value (aluValue)
   );

   serialDivider iDiv (
      .clk   (clk),
      .reset (reset),
      .start (divStart),
      .op    (headOp),
      .done  (divDone),
      .value (divValue)
   );

   assign pop      = (state == idle) & notEmpty;  // Take every head while idle
   assign divStart = pop & headOp.isDivide;

   always_ff @(posedge clk) begin
      if (!reset) begin
         state       <= idle;
         resultValid <= 1'b0;
      end else begin
         resultValid <= 1'b0;
         case (state)
            idle: begin
               if (divStart) begin
                  state <= dividing;
               end else if (pop) begin
                  resultValid <= 1'b1;  // One-cycle ALU path
               end
            end
            default: begin
               if (divDone) begin
                  state       <= idle;
                  resultValid <= 1'b1;
               end
            end
         endcase
      end
   end

   // Result and held rd are payload
   always_ff @(posedge clk) begin
      if (divStart) divRd <= headOp.rd;
      if (state == idle && pop && !headOp.isDivide) begin
         result <= '{rd: headOp.rd, value: aluValue};
      end else if (state == dividing && divDone) begin
         result <= '{rd: divRd, value: divValue};
      end
   end

endmodule

// File: design/execTop.sv
// Integer execute path top: decoder, operation queue and execute unit in a row
`timescale 1ns/1ps

module execTop import rvIsaPkg::*, execPkg::*; #(
   parameter int queueDepth = 4
) (
   input  logic      clk,
   input  logic      reset,
   input  logic      issueValid,
   input  wordT      issueInstr,
   input  wordT      issueRs1,
   input  wordT      issueRs2,
   output logic      resultValid,
   output aluResultT result
);

   logic  decValid;
   aluOpT decOp;
   aluOpT popOp;
   logic  notEmpty;
   logic  pop;

   opDecoder iDecoder (
      .clk        (clk),
      .reset      (reset),
      .issueValid (issueValid),
      .issueInstr (issueInstr),
      .issueRs1   (issueRs1),
      .issueRs2   (issueRs2),
      .decValid   (decValid),
      .decOp      (decOp)
   );

   opQueue #(.queueDepth(queueDepth)) iQueue (
      .clk      (clk),
      .reset    (reset),
      .push     (decValid),
      .pushOp   (decOp),
      .pop      (pop),
      .popOp    (popOp),
      .notEmpty (notEmpty)
   );

   execUnit iExec (
      .clk         (clk),
      .reset       (reset),
      .notEmpty    (notEmpty),
      .headOp      (popOp),
      .pop         (pop),
      .resultValid (resultValid),
      .result      (result)
   );

endmodule

// File: tests/execTb.sv
// Testbench for the integer execute path driving random ALU, multiply and divide streams against a reference
`timescale 1ns/1ps

module execTb import rvIsaPkg::*, execPkg::*; #(
   parameter int queueDepth = 4
) ();

   logic      clk;
   logic      reset;
   logic      issueValid;
   wordT      issueInstr;
   wordT      issueRs1;
   wordT      issueRs2;
   logic      resultValid;
   aluResultT result;

   logic [31:0] lfsrState = 32'h7313_c51c;
   aluResultT   expQ [$];       // Expected results in issue order
   int          aluCount = 0;   // ALU instructions issued
   int          resultCount = 0;

   execTop #(.queueDepth(queueDepth)) i_dut (
      .clk         (clk),
      .reset       (reset),
      .issueValid  (issueValid),
      .issueInstr  (issueInstr),
      .issueRs1    (issueRs1),
      .issueRs2    (issueRs2),
      .resultValid (resultValid),
      .result      (result)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;  // 4 ns period
   end

   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] randBits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsrState[0]};
         lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'h8020_0003 : lfsrState >> 1;
      end
      return r;
   endfunction

   // Operands biased toward the corners
   function automatic wordT randOperand();
      case (randBits(3))
         0:       return 32'h0000_0000;
         1:       return 32'hffff_ffff;  // Minus one
         2:       return 32'h8000_0000;  // Most negative
         3:       return 32'(randBits(4));
         default: return randBits(32);
      endcase
   endfunction

   function automatic wordT makeReg(input funct7T f7, input funct3T f3, input regIdT rd);
      return {f7, 10'(randBits(10)), f3, rd, opcodeOp};  // rs2 and rs1 fields unused
   endfunction

   function automatic wordT makeImm(input logic [11:0] imm, input funct3T f3, input regIdT rd);
      return {imm, 5'(randBits(5)), f3, rd, opcodeOpImm};
   endfunction

   function automatic wordT randomBase();
      funct3T      f3;
      regIdT       rd;
      logic [11:0] imm;
      f3 = funct3T'(randBits(3));
      rd = regIdT'(randBits(5));
      if (randBits(1) == 1) begin
         if ((f3 == f3AddSub || f3 == f3Sr) && randBits(1) == 1) begin
            return makeReg(7'h20, f3, rd);  // SUB or SRA
         end
         return makeReg(7'h00, f3, rd);
      end
      imm = 12'(randBits(12));  // ADDI may carry bit 30 as a plain immediate bit
      if (f3 == f3Sll) imm[11:5] = 7'h00;
      if (f3 == f3Sr) imm[11:5] = (randBits(1) == 1) ? 7'h20 : 7'h00;  // SRAI or SRLI
      return makeImm(imm, f3, rd);
   endfunction

   function automatic wordT randomMulDiv(input logic divide);
      return makeReg(funct7MulDiv, {divide, 2'(randBits(2))}, regIdT'(randBits(5)));
   endfunction

   // Opcodes outside OP and OP-IMM
   function automatic wordT randomOther();
      opcodeT opc;
      case (randBits(2))
         0:       opc = 7'b000_0011;  // LOAD
         1:       opc = 7'b010_0011;  // STORE
         2:       opc = 7'b110_0011;  // BRANCH
         default: opc = 7'b011_0111;  // LUI
      endcase
      return {25'(randBits(25)), opc};
   endfunction

   // Expected result by the RV32IM rules
   function automatic aluResultT refResult(input wordT instr, input wordT a, input wordT rs2);
      wordT        b;
      wordT        v;
      funct3T      f3;
      logic        isImm;
      longint      sa;
      longint      sb;
      longint      ua;
      longint      ub;
      logic [63:0] prod;
      f3    = instr[14:12];
      isImm = instr[6:0] == opcodeOpImm;
      b     = isImm ? {{20{instr[31]}}, instr[31:20]} : rs2;
      sa    = $signed(a);
      sb    = $signed(b);
      ua    = {32'b0, a};
      ub    = {32'b0, b};
      if (!isImm && instr[31:25] == funct7MulDiv) begin
         prod = (f3 == 3'd3) ? ua * ub : (f3 == 3'd2) ? sa * ub : sa * sb;
         case (f3)
            3'd0:    v = prod[31:0];
            3'd4:    v = (b == 0) ? 32'hffff_ffff : (a == 32'h8000_0000 && b == 32'hffff_ffff)
                         ? a : wordT'(sa / sb);
            3'd5:    v = (b == 0) ? 32'hffff_ffff : wordT'(ua / ub);
            3'd6:    v = (b == 0) ? a : wordT'(sa % sb);  // Overflow leaves zero
            3'd7:    v = (b == 0) ? a : wordT'(ua % ub);
            default: v = prod[63:32];                    // MULH, MULHSU, MULHU
         endcase
      end else begin
         case (f3)
            f3AddSub: v = (!isImm && instr[30]) ? a - b : a + b;
            f3Sll:    v = a << b[4:0];
            f3Slt:    v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            f3Sltu:   v = (a < b) ? 32'd1 : 32'd0;
            f3Xor:    v = a ^ b;
            f3Sr: begin
               if (instr[30]) v = $signed(a) >>> b[4:0];
               else v = a >> b[4:0];
            end
            f3Or:     v = a | b;
            default:  v = a & b;
         endcase
      end
      return '{rd: instr[11:7], value: v};
   endfunction

   task automatic stopOnError();
      $display("TEST FAIL");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic checkResult(input aluResultT got, input aluResultT exp);
      if (got.rd !== exp.rd) begin
         $display("CHECK FAILED at %0t ns: result.rd got %0d expected %0d", $time, got.rd, exp.rd);
         stopOnError();
      end
      if (got.value !== exp.value) begin
         $display("CHECK FAILED at %0t ns: result.value got %h expected %h",
                  $time, got.value, exp.value);
         stopOnError();
      end
   endtask

   task automatic checkFlag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
         stopOnError();
      end
   endtask

   // Called on a falling edge; stalls while the pipeline holds queueDepth+2
   task automatic issueOne(input wordT instr, input wordT rs1, input wordT rs2, input int gap);
      int waitCycles;
      waitCycles = 0;
      while (aluCount - resultCount >= queueDepth + 2) begin
         @(negedge clk);
         waitCycles++;
         if (waitCycles > 100) begin
            $display("Timeout at %0t ns: no result came back while issue was stalled", $time);
            stopOnError();
         end
      end
      issueValid = 1'b1;
      issueInstr = instr;
      issueRs1   = rs1;
      issueRs2   = rs2;
      if (instr[6:0] == opcodeOp || instr[6:0] == opcodeOpImm) begin
         expQ.push_back(refResult(instr, rs1, rs2));
         aluCount++;
      end
      @(negedge clk);
      issueValid = 1'b0;
      repeat (gap) @(negedge clk);
   endtask

   task automatic sendOp(input wordT instr, input logic spread);
      wordT rs1;
      wordT rs2;
      int   gap;
      rs1 = randOperand();
      rs2 = randOperand();
      gap = (spread && randBits(2) == 0) ? int'(randBits(3)) : 0;  // Mostly back to back
      issueOne(instr, rs1, rs2, gap);
   endtask

   // Scoreboard sampled on the rising edge before outputs move
   always @(posedge clk) begin
      if (reset === 1'b1 && resultValid === 1'b1) begin
         if (expQ.size() == 0) begin
            $display("Result strobe at %0t ns with no ALU instruction outstanding", $time);
            stopOnError();
         end else begin
            checkResult(result, expQ.pop_front());
            resultCount++;
         end
      end
   end

   initial begin
      int waitCycles;
      reset      = 1'b0;
      issueValid = 1'b0;
      issueInstr = '0;
      issueRs1   = '0;
      issueRs2   = '0;
      repeat (5) @(negedge clk);
      reset = 1'b1;
      repeat (10) begin  // Quiet after reset
         @(negedge clk);
         checkFlag("resultValid", resultValid, 1'b0);
      end
      repeat (300) sendOp(randomBase(), 1'b0);
      repeat (200) sendOp(randomMulDiv(1'b0), 1'b0);
      for (int k = 4; k < 8; k++) begin
         issueOne(makeReg(funct7MulDiv, funct3T'(k), 5'd7), 32'h8000_0000, 32'hffff_ffff, 0);
         issueOne(makeReg(funct7MulDiv, funct3T'(k), 5'd9), randBits(32), 32'h0, 0);
      end
      repeat (60) sendOp(randomMulDiv(1'b1), 1'b0);
      repeat (400) begin  // Mixed stream
         case (randBits(3))
            0:       sendOp(randomMulDiv(1'b1), 1'b1);
            1:       sendOp(randomMulDiv(1'b0), 1'b1);
            2:       sendOp(randomOther(), 1'b1);
            default: sendOp(randomBase(), 1'b1);
         endcase
      end
      waitCycles = 0;
      while (expQ.size() != 0) begin
         @(negedge clk);
         waitCycles++;
         if (waitCycles > 400) begin
            $display("Timeout at %0t ns: %0d results never arrived", $time, expQ.size());
            stopOnError();
         end
      end
      repeat (20) @(negedge clk);  // Stray strobes would hit the scoreboard here
      $display("TEST PASS");
      $finish;
   end

endmodule

// File: src.f
design/rvIsaPkg.sv
design/execPkg.sv
design/opDecoder.sv
design/opQueue.sv
design/intAlu.sv
design/serialDivider.sv
design/execUnit.sv
design/execTop.sv
tests/execTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the execute-path testbench with Verilator and run it.
# The exit status is the simulator's own, nonzero after $fatal.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f src.f --top-module execTb -o execSim \
   && ./obj_dir/execSim \
   || { echo "execTb build or simulation failed"; exit 1; }
